/* design/alut_addr_checker.sv */
`default_nettype none

module alut_addr_checker
(
   input  wire logic                    pclk22,
   input  wire logic                    n_p_reset22,
   input  wire logic                    req_valid,        // one-cycle request strobe
   input  wire alut_pkg::alut_req_t     req,
   input  wire logic [31:0]             curr_time,
   input  wire logic                    age_confirmed,
   input  wire logic                    age_ok,
   input  wire alut_pkg::alut_entry_t   rdata,
   output alut_pkg::alut_mem_req_t      mem_req,
   output logic                         check_age,        // held until confirm
   output logic [31:0]                  last_accessed,
   output logic                         add_check_active,
   output logic                         done,             // one-cycle, res valid
   output alut_pkg::alut_res_t          res,
   output logic                         active
);

   alut_pkg::alut_addr_state_e   state;
   alut_pkg::alut_req_t          req_q;               // request held for the op
   logic [alut_pkg::ALUT_AW-1:0] idx;                 // folded table index
   logic                         match;               // lookup found its mac
   logic [1:0]                   port_q;              // stored port of a match
   logic [31:0]                  stamp_q;             // stored time of a match

   //----------------------------------------------------------------------
   // request capture and index fold
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22)
   begin
      if (req_valid)
         req_q <= req;
   end

   assign idx   = req_q.mac[7:0] ^ req_q.mac[15:8];    // low byte xor second byte
   assign match = !req_q.learn && rdata.valid && (rdata.mac == req_q.mac);

   //----------------------------------------------------------------------
   // learn / lookup state machine
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         state <= alut_pkg::addr_idle;
         done  <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            alut_pkg::addr_idle:
               if (req_valid)
                  state <= alut_pkg::addr_access;
            alut_pkg::addr_access:
               if (match)
                  state <= alut_pkg::addr_wait_age;  // needs a verdict first
               else
               begin
                  state <= alut_pkg::addr_idle;      // learn written or plain miss
                  done  <= 1'b1;
               end
            alut_pkg::addr_wait_age:
               if (age_confirmed)
               begin
                  state <= alut_pkg::addr_idle;
                  done  <= 1'b1;
               end
            default:
               state <= alut_pkg::addr_idle;
         endcase
      end
   end

   //----------------------------------------------------------------------
   // stored entry fields and result
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22)
   begin
      if (state == alut_pkg::addr_access)
      begin
         port_q  <= rdata.port;
         stamp_q <= rdata.last_acc;
         res     <= '0;                             // learn and miss report no hit
      end
      else if (state == alut_pkg::addr_wait_age && age_confirmed)
      begin
         res.hit  <= age_ok;                        // hit only if still in date
         res.port <= age_ok ? port_q : 2'd0;
      end
   end

   assign check_age        = (state == alut_pkg::addr_wait_age);
   assign add_check_active = (state == alut_pkg::addr_wait_age);
   assign last_accessed    = stamp_q;
   assign active           = (state != alut_pkg::addr_idle);

   // learn writes a valid entry stamped with the current time
   assign mem_req = '{addr:  idx,
                      we:    (state == alut_pkg::addr_access) && req_q.learn,
                      wdata: '{valid:    1'b1,
                               last_acc: curr_time,
                               port:     req_q.port,
                               mac:      req_q.mac}};

   a_req_idle: assert property (
      @(posedge pclk22) disable iff (!n_p_reset22)
      req_valid |-> !active)
   else $error("req_valid while address checker busy");

endmodule

`default_nettype wire

/* design/alut_age_checker.sv */
`default_nettype none

module alut_age_checker
(
   input  wire logic                    pclk22,
   input  wire logic                    n_p_reset22,
   input  wire alut_pkg::alut_cmd_e     command,          // pulse when not cmd_none
   input  wire logic [7:0]              div_clk,          // time base divider
   input  wire logic [31:0]             best_bfr_age,     // max in-date age
   input  wire logic                    check_age,        // verdict wanted by addr checker
   input  wire logic [31:0]             last_accessed,    // stamp from addr checker
   input  wire logic                    add_check_active, // working for addr checker
   input  wire alut_pkg::alut_entry_t   rdata,
   output alut_pkg::alut_mem_req_t      mem_req,
   output logic [31:0]                  curr_time,
   output logic                         age_confirmed,    // qualifies age_ok
   output logic                         age_ok,           // 1 = still in date
   output logic                         inval_in_prog,
   output logic                         age_check_active,
   output logic [47:0]                  lst_inv_mac,
   output logic [1:0]                   lst_inv_port
);

   alut_pkg::alut_age_state_e   state;
   alut_pkg::alut_age_state_e   nxt_state;
   logic [alut_pkg::ALUT_AW-1:0] addr_q;              // scan / sweep address
   logic [7:0]                  clk_div_cnt;
   logic                        tick;                 // time base step
   logic                        last_addr;            // scan at top of table
   logic [31:0]                 stamp;                // time stamp under test
   logic [31:0]                 elapsed;              // time since stamp

   //----------------------------------------------------------------------
   // current time, one step every div_clk+1 cycles
   //----------------------------------------------------------------------
   assign tick = (clk_div_cnt == div_clk);

   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         clk_div_cnt <= '0;
         curr_time   <= '0;
      end
      else if (tick)
      begin
         clk_div_cnt <= '0;
         curr_time   <= curr_time + 32'd1;
      end
      else
         clk_div_cnt <= clk_div_cnt + 8'd1;
   end

   //----------------------------------------------------------------------
   // state machine
   //----------------------------------------------------------------------
   assign last_addr = (addr_q == alut_pkg::ALUT_MAX_ADDR);

   always_comb
   begin
      nxt_state = state;
      case (state)
         alut_pkg::age_idle:
            if (command == alut_pkg::cmd_inval_aged)
               nxt_state = alut_pkg::age_inval_rd;
            else if (command == alut_pkg::cmd_inval_all)
               nxt_state = alut_pkg::age_inval_all;
            else if (check_age)
               nxt_state = alut_pkg::age_chk;
         alut_pkg::age_inval_rd:
            nxt_state = alut_pkg::age_chk;
         alut_pkg::age_inval_wr:                       // more to scan unless at top
            nxt_state = last_addr ? alut_pkg::age_idle : alut_pkg::age_inval_rd;
         alut_pkg::age_inval_all:
            if (last_addr)
               nxt_state = alut_pkg::age_idle;
         alut_pkg::age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)                  // verdict handed back
                  nxt_state = alut_pkg::age_idle;
               else if (rdata.valid && !age_ok)       // aged, clear it
                  nxt_state = alut_pkg::age_inval_wr;
               else if (last_addr)                    // final check done
                  nxt_state = alut_pkg::age_idle;
               else
                  nxt_state = alut_pkg::age_inval_rd;
            end
         default:
            nxt_state = alut_pkg::age_idle;
      endcase
   end

   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
         state <= alut_pkg::age_idle;
      else
         state <= nxt_state;
   end

   assign age_check_active = (state != alut_pkg::age_idle);

   //----------------------------------------------------------------------
   // scan address and memory access, writes are always zero words
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
         addr_q <= '0;
      else if (state == alut_pkg::age_inval_rd || state == alut_pkg::age_inval_all)
         addr_q <= addr_q + 1'b1;                   // sweep wraps back to 0
   end

   assign mem_req = '{addr:  addr_q,
                      we:    (state == alut_pkg::age_inval_wr) ||
                             (state == alut_pkg::age_inval_all),
                      wdata: '0};

   //----------------------------------------------------------------------
   // age verdict, elapsed time wraps through ALUT_MAX_CNT
   //----------------------------------------------------------------------
   assign stamp   = add_check_active ? last_accessed : rdata.last_acc;
   assign elapsed = (curr_time >= stamp) ? (curr_time - stamp)
                                         : (curr_time + (alut_pkg::ALUT_MAX_CNT - stamp));

   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         // one-cycle confirm after entering age_chk
         age_confirmed <= (state == alut_pkg::age_chk) && !age_confirmed;
         age_ok        <= (state == alut_pkg::age_chk) && (best_bfr_age > elapsed);
      end
   end

   //----------------------------------------------------------------------
   // invalidation status and last cleared entry
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         inval_in_prog <= 1'b0;
         lst_inv_mac   <= '0;
         lst_inv_port  <= '0;
      end
      else if (state == alut_pkg::age_inval_wr)
      begin
         inval_in_prog <= !last_addr;               // clear at top ends the scan
         lst_inv_mac   <= rdata.mac;                // read before the zero lands
         lst_inv_port  <= rdata.port;
      end
      else if (state == alut_pkg::age_chk && age_confirmed && !add_check_active && last_addr)
         inval_in_prog <= 1'b0;
   end

   // clearing writes never while the addr checker holds the memory
   a_write_owner: assert property (
      @(posedge pclk22) disable iff (!n_p_reset22)
      mem_req.we |-> !add_check_active)
   else $error("age checker write while the address checker holds the memory");

   a_cmd_idle: assert property (
      @(posedge pclk22) disable iff (!n_p_reset22)
      (command != alut_pkg::cmd_none) |-> (state == alut_pkg::age_idle) && !check_age)
   else $error("command issued while table is busy");

endmodule

`default_nettype wire

/* design/alut_mem.sv */
`default_nettype none

module alut_mem
(
   input  wire logic                    pclk22,
   input  wire logic                    n_p_reset22,
   input  wire alut_pkg::alut_mem_req_t age_req,    // age checker access
   input  wire alut_pkg::alut_mem_req_t addr_req,   // address checker access
   input  wire logic                    age_owns,   // age checker has the port
   output alut_pkg::alut_entry_t        rdata
);

   alut_pkg::alut_entry_t   table_q [0:alut_pkg::ALUT_MAX_ADDR];
   alut_pkg::alut_mem_req_t sel;                    // winning requester

   assign sel = age_owns ? age_req : addr_req;

   //----------------------------------------------------------------------
   // table storage, one write per clock
   //----------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         for (int i = 0; i <= alut_pkg::ALUT_MAX_ADDR; i++)
            table_q[i] <= '0;                       // every entry starts invalid
      end
      else if (sel.we)
         table_q[sel.addr] <= sel.wdata;            // lands at this edge
   end

   // read is combinational off the selected address
   assign rdata = table_q[sel.addr];

   // the checker without the port must never try to write
   a_no_stray_write: assert property (
      @(posedge pclk22) disable iff (!n_p_reset22)
      age_owns ? !addr_req.we : !age_req.we)
   else $error("write strobe from checker that does not own the memory");

endmodule

`default_nettype wire

/* design/alut_pkg.sv */
`default_nettype none

package alut_pkg;

   //----------------------------------------------------------------------
   // table geometry and time arithmetic
   //----------------------------------------------------------------------
   localparam int unsigned ALUT_AW       = 8;               // table index width
   localparam int unsigned ALUT_MAX_ADDR = 255;             // last table index
   localparam logic [31:0] ALUT_MAX_CNT  = 32'hffff_ffff;   // time counter wrap point

   // one table word, valid on top, mac in the low bits
   typedef struct packed {
      logic        valid;      // entry in use
      logic [31:0] last_acc;   // time stamp when learned
      logic [1:0]  port;       // port the mac was seen on
      logic [47:0] mac;        // learned mac address
   } alut_entry_t;

   // command bus codes
   typedef enum logic [1:0] {
      cmd_none       = 2'b00,
      cmd_reserved   = 2'b01,
      cmd_inval_aged = 2'b10,
      cmd_inval_all  = 2'b11
   } alut_cmd_e;

   typedef struct packed {
      logic        learn;      // 0 means lookup
      logic [47:0] mac;
      logic [1:0]  port;       // only used by learn
   } alut_req_t;

   typedef struct packed {
      logic       hit;
      logic [1:0] port;
   } alut_res_t;

   // one memory access, from either checker
   typedef struct packed {
      logic [ALUT_AW-1:0] addr;
      logic               we;
      alut_entry_t        wdata;
   } alut_mem_req_t;

   //----------------------------------------------------------------------
   // state machine encodings
   //----------------------------------------------------------------------
   typedef enum logic [2:0] {
      age_idle      = 3'b000,
      age_inval_rd  = 3'b001,   // step scan address
      age_inval_wr  = 3'b010,   // clear an aged entry
      age_inval_all = 3'b011,   // sweep zeros through the table
      age_chk       = 3'b100    // verdict for either checker
   } alut_age_state_e;

   typedef enum logic [1:0] {
      addr_idle     = 2'b00,
      addr_access   = 2'b01,    // read or write the indexed entry
      addr_wait_age = 2'b10     // waiting on the age verdict
   } alut_addr_state_e;

endpackage

`default_nettype wire

/* design/alut_top.sv */
`default_nettype none

module alut_top
(
   input  wire logic                    pclk22,
   input  wire logic                    n_p_reset22,
   input  wire logic                    req_valid,
   input  wire alut_pkg::alut_req_t     req,
   input  wire alut_pkg::alut_cmd_e     command,
   input  wire logic [7:0]              div_clk,
   input  wire logic [31:0]             best_bfr_age,
   output logic                         done,
   output alut_pkg::alut_res_t          res,
   output logic                         busy,
   output logic                         age_check_active,
   output logic                         inval_in_prog,
   output logic [47:0]                  lst_inv_mac,
   output logic [1:0]                   lst_inv_port,
   output logic [31:0]                  curr_time
);

   alut_pkg::alut_mem_req_t age_mem_req;
   alut_pkg::alut_mem_req_t addr_mem_req;
   alut_pkg::alut_entry_t   rdata;
   logic                    check_age;
   logic [31:0]             last_accessed;
   logic                    add_check_active;
   logic                    age_confirmed;
   logic                    age_ok;
   logic                    active;               // address checker busy
   logic                    age_owns;             // memory port to age checker

   assign age_owns = age_check_active && !add_check_active;
   assign busy     = active || age_check_active;

   alut_age_checker i_age (
      .pclk22, .n_p_reset22,
      .command, .div_clk, .best_bfr_age,
      .check_age, .last_accessed, .add_check_active,
      .rdata,
      .mem_req (age_mem_req),
      .curr_time, .age_confirmed, .age_ok,
      .inval_in_prog, .age_check_active,
      .lst_inv_mac, .lst_inv_port
   );

   alut_addr_checker i_addr (
      .pclk22, .n_p_reset22,
      .req_valid, .req, .curr_time,
      .age_confirmed, .age_ok, .rdata,
      .mem_req (addr_mem_req),
      .check_age, .last_accessed, .add_check_active,
      .done, .res, .active
   );

   alut_mem i_mem (
      .pclk22, .n_p_reset22,
      .age_req  (age_mem_req),
      .addr_req (addr_mem_req),
      .age_owns,
      .rdata
   );

endmodule

`default_nettype wire

/* filelist.f */
design/alut_pkg.sv
design/alut_mem.sv
design/alut_age_checker.sv
design/alut_addr_checker.sv
design/alut_top.sv
sim/alut_monitor.sv
sim/alut_tb.sv

/* sim/alut_golden.txt */
# name op mac port best_bfr_age exp_hit exp_port exp_lst_inv_mac exp_lst_inv_port
# numbers in hex; lst_inv columns are checked on inval_aged and inval_all steps only
# learn four entries (index 45, 30, c3, 83) and look them up in date
learn_a          learn       001122334401 1 ffffffff 0 0 000000000000 0
learn_b          learn       00aabbcc1020 2 ffffffff 0 0 000000000000 0
learn_c          learn       02000000c003 3 ffffffff 0 0 000000000000 0
learn_d          learn       060504030281 0 ffffffff 0 0 000000000000 0
look_a           lookup      001122334401 0 ffffffff 1 1 000000000000 0
look_b           lookup      00aabbcc1020 0 ffffffff 1 2 000000000000 0
look_c           lookup      02000000c003 0 ffffffff 1 3 000000000000 0
look_d           lookup      060504030281 0 ffffffff 1 0 000000000000 0
# misses, empty index 77 and a different mac on index 45
miss_new         lookup      000000000077 0 ffffffff 0 0 000000000000 0
miss_alias       lookup      000000004500 0 ffffffff 0 0 000000000000 0
# zero age makes every entry out of date, entries stay valid
aged_look_a      lookup      001122334401 0 00000000 0 0 000000000000 0
aged_look_c      lookup      02000000c003 0 00000000 0 0 000000000000 0
fresh_look_a     lookup      001122334401 0 ffffffff 1 1 000000000000 0
# aged scan clears all four, last one cleared is index c3
inval_aged       inval_aged  000000000000 0 00000000 0 0 02000000c003 3
gone_a           lookup      001122334401 0 ffffffff 0 0 000000000000 0
gone_b           lookup      00aabbcc1020 0 ffffffff 0 0 000000000000 0
gone_c           lookup      02000000c003 0 ffffffff 0 0 000000000000 0
gone_d           lookup      060504030281 0 ffffffff 0 0 000000000000 0
# scan left the address at ff, this sweep clears ff and wraps it to 0
inval_all_tail   inval_all   000000000000 0 ffffffff 0 0 02000000c003 3
relearn_a        learn       001122334401 1 ffffffff 0 0 000000000000 0
relearn_b        learn       00aabbcc1020 2 ffffffff 0 0 000000000000 0
relearn_d        learn       060504030281 0 ffffffff 0 0 000000000000 0
back_a           lookup      001122334401 0 ffffffff 1 1 000000000000 0
back_d           lookup      060504030281 0 ffffffff 1 0 000000000000 0
# full sweep from index 0
inval_all        inval_all   000000000000 0 ffffffff 0 0 02000000c003 3
cleared_a        lookup      001122334401 0 ffffffff 0 0 000000000000 0
cleared_b        lookup      00aabbcc1020 0 ffffffff 0 0 000000000000 0
cleared_d        lookup      060504030281 0 ffffffff 0 0 000000000000 0
# table still learns after the sweep, index 01
learn_g          learn       0a0b0c0d0e0f 2 ffffffff 0 0 000000000000 0
look_g           lookup      0a0b0c0d0e0f 0 ffffffff 1 2 000000000000 0
still_gone_a     lookup      001122334401 0 ffffffff 0 0 000000000000 0

/* sim/alut_monitor.sv */
`default_nettype none

module alut_monitor
(
   input  wire logic                  pclk22,
   input  wire logic                  n_p_reset22,
   input  wire logic                  done,
   input  wire alut_pkg::alut_res_t   res,
   input  wire logic                  busy,
   input  wire logic                  age_check_active,
   input  wire logic                  inval_in_prog,
   input  wire logic [47:0]           lst_inv_mac,
   input  wire logic [1:0]            lst_inv_port,
   input  wire logic [31:0]           curr_time,
   input  wire logic [7:0]            div_clk          // time base setting
);

   string       name_q;            // test now outstanding
   string       op_q;
   logic        armed = 1'b0;      // a step waits for its result
   logic        exp_hit;
   logic [1:0]  exp_port;
   logic [47:0] exp_lst_mac;
   logic [1:0]  exp_lst_port;
   logic        age_active_d = 1'b0;
   logic        busy_seen = 1'b0;  // busy rose while the step was outstanding
   int          edges = 0;         // clock edges since reset released
   logic        time_err = 1'b0;   // curr_time already reported wrong
   int          checked_cnt = 0;   // steps finished, good or bad
   int          pass_cnt = 0;
   int          fail_cnt = 0;

   // called by the testbench just before it drives a step
   task automatic expect_step(input string name, input string op, input logic hit,
                              input logic [1:0] port, input logic [47:0] lst_mac,
                              input logic [1:0] lst_port);
      name_q       = name;
      op_q         = op;
      exp_hit      = hit;
      exp_port     = port;
      exp_lst_mac  = lst_mac;
      exp_lst_port = lst_port;
      busy_seen    = 1'b0;
      armed        = 1'b1;
   endtask

   task automatic record_result(input logic ok);
      if (ok)
      begin
         pass_cnt++;
         $display("PASS %s", name_q);
      end
      else
         fail_cnt++;
      checked_cnt++;
      armed = 1'b0;
   endtask

   //----------------------------------------------------------------------
   // sample mid-cycle, every output is settled by the falling edge
   //----------------------------------------------------------------------
   always @(negedge pclk22)
   begin
      if (armed && busy)
         busy_seen = 1'b1;
      if (n_p_reset22 && done)
      begin
         if (!armed || op_q == "inval_aged" || op_q == "inval_all")
         begin
            $display("done pulsed while no learn or lookup was outstanding");
            fail_cnt++;
         end
         else if (!busy_seen)
         begin
            $display("busy never went high during %s", name_q);
            record_result(1'b0);
         end
         else if (res.hit !== exp_hit || res.port !== exp_port)
         begin
            $display("ERROR %s: expected hit %0d port %0d, actual hit %0d port %0d",
                     name_q, exp_hit, exp_port, res.hit, res.port);
            record_result(1'b0);
         end
         else
            record_result(1'b1);
      end
      // end of an invalidation is age_check_active falling
      if (n_p_reset22 && armed && age_active_d && !age_check_active &&
          (op_q == "inval_aged" || op_q == "inval_all"))
      begin
         if (!busy_seen)
         begin
            $display("busy never went high during %s", name_q);
            record_result(1'b0);
         end
         else if (lst_inv_mac !== exp_lst_mac || lst_inv_port !== exp_lst_port ||
                  inval_in_prog !== 1'b0)
         begin
            $display("ERROR %s: expected %h port %0d in_prog 0, actual %h port %0d in_prog %0b",
                     name_q, exp_lst_mac, exp_lst_port, lst_inv_mac, lst_inv_port,
                     inval_in_prog);
            record_result(1'b0);
         end
         else
            record_result(1'b1);
      end
      age_active_d = age_check_active;
      // time base, one step per div_clk+1 edges after reset
      if (!n_p_reset22)
         edges = 0;
      else
      begin
         if (!time_err && curr_time !== edges / (div_clk + 1))
         begin
            $display("ERROR curr_time: expected %0d, actual %0d",
                     edges / (div_clk + 1), curr_time);
            fail_cnt++;
            time_err = 1'b1;                        // first mismatch only
         end
         edges++;
      end
   end

endmodule

`default_nettype wire

/* sim/alut_tb.sv */
`default_nettype none

module alut_tb;

   localparam int CYCLES_PER_RECORD = 1000;   // a full aged scan fits well inside

   // numeric fields of one golden record
   typedef struct packed {
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] age;              // best_bfr_age for this step
      logic        exp_hit;
      logic [1:0]  exp_port;
      logic [47:0] exp_lst_mac;
      logic [1:0]  exp_lst_port;
   } step_t;

   logic                pclk22;
   logic                n_p_reset22;
   logic                req_valid;
   alut_pkg::alut_req_t req;
   alut_pkg::alut_cmd_e command;
   logic [7:0]          div_clk;
   logic [31:0]         best_bfr_age;
   logic                done;
   alut_pkg::alut_res_t res;
   logic                busy;
   logic                age_check_active;
   logic                inval_in_prog;
   logic [47:0]         lst_inv_mac;
   logic [1:0]          lst_inv_port;
   logic [31:0]         curr_time;

   step_t steps[$];
   string names[$];
   string ops[$];
   logic  load_ok = 1'b0;
   int    cycle_limit = 0;         // set once the golden file is read
   int    cycle_cnt = 0;

   alut_top i_dut (.*);

   alut_monitor i_mon (
      .pclk22, .n_p_reset22, .done, .res, .busy,
      .age_check_active, .inval_in_prog, .lst_inv_mac, .lst_inv_port,
      .curr_time, .div_clk
   );

   initial
   begin
      pclk22 = 1'b0;
      forever #2 pclk22 = ~pclk22;
   end

   //----------------------------------------------------------------------
   // golden file, one step per line, # lines skipped
   //----------------------------------------------------------------------
   task automatic load_golden();
      int          fd;
      int          n;
      string       line;
      string       name;
      string       op;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] age;
      logic        hit;
      logic [1:0]  eport;
      logic [47:0] lmac;
      logic [1:0]  lport;
      fd = $fopen("sim/alut_golden.txt", "r");
      load_ok = (fd != 0);
      if (fd == 0)
         $display("golden file sim/alut_golden.txt could not be opened");
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() < 2 || line[0] == "#")
               continue;
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h",
                        name, op, mac, port, age, hit, eport, lmac, lport);
            if (n != 9 || !(op == "learn" || op == "lookup" ||
                            op == "inval_aged" || op == "inval_all"))
            begin
               $display("golden file has a malformed record: %s", line);
               load_ok = 1'b0;
            end
            else
            begin
               steps.push_back('{mac: mac, port: port, age: age, exp_hit: hit,
                                 exp_port: eport, exp_lst_mac: lmac, exp_lst_port: lport});
               names.push_back(name);
               ops.push_back(op);
            end
         end
         $fclose(fd);
      end
   endtask

   // one step: wait for idle, pulse the request or command, wait for the check
   task automatic run_step(input int i);
      @(posedge pclk22);
      while (busy)
         @(posedge pclk22);
      i_mon.expect_step(names[i], ops[i], steps[i].exp_hit, steps[i].exp_port,
                        steps[i].exp_lst_mac, steps[i].exp_lst_port);
      best_bfr_age <= steps[i].age;                 // level, held until the next step
      if (ops[i] == "learn" || ops[i] == "lookup")
      begin
         req_valid <= 1'b1;
         req       <= '{learn: (ops[i] == "learn"), mac: steps[i].mac, port: steps[i].port};
      end
      else if (ops[i] == "inval_aged")
         command <= alut_pkg::cmd_inval_aged;
      else
         command <= alut_pkg::cmd_inval_all;
      @(posedge pclk22);
      req_valid <= 1'b0;                            // strobes last one cycle
      command   <= alut_pkg::cmd_none;
      while (i_mon.checked_cnt <= i)
         @(posedge pclk22);
   endtask

   //----------------------------------------------------------------------
   // main sequence and summary
   //----------------------------------------------------------------------
   initial
   begin
      n_p_reset22  = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      command      = alut_pkg::cmd_none;
      div_clk      = 8'd3;                          // time steps every 4 cycles
      best_bfr_age = '1;
      load_golden();
      cycle_limit = steps.size() * CYCLES_PER_RECORD;
      repeat (3) @(posedge pclk22);
      n_p_reset22 <= 1'b1;
      if (load_ok)
      begin
         for (int i = 0; i < steps.size(); i++)
            run_step(i);
      end
      @(posedge pclk22);
      $display("tests %0d: passed %0d, failed %0d", steps.size(), i_mon.pass_cnt,
               i_mon.fail_cnt);
      if (load_ok && steps.size() > 0 && i_mon.fail_cnt == 0 &&
          i_mon.pass_cnt == steps.size())
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // watchdog, limit scales with the number of golden steps
   initial
   begin
      wait (cycle_limit != 0);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge pclk22);
         cycle_cnt++;
      end
      $display("timeout: the run timed out waiting for the DUT after %0d cycles", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
